// ==== src/la_commit_pkg.sv ====
package la_commit_pkg;

    // Datapath and register file geometry
    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;
    parameter int NUM_REGS   = 32;

    // 8-entry fetch target queue
    parameter int FTQ_ID_W = 3;

    // Default number of commit lanes per cycle
    parameter int COMMIT_LANES = 2;

    // Debug trace write enable is four bits wide
    parameter int DEBUG_WEN_W = 4;

    // One committed writeback from the control unit
    typedef struct packed {
        logic                  we;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } commit_rec_t;

    // Redirect request from one execute lane
    typedef struct packed {
        logic                taken;
        logic [XLEN-1:0]     target;
        logic [FTQ_ID_W-1:0] ftq_id;
    } branch_req_t;

    // Redirect sources raised by the control unit
    typedef struct packed {
        logic                excp;
        logic                tlbrefill;
        logic                ertn;
        logic                idle;
        logic [XLEN-1:0]     idle_pc;
        logic [FTQ_ID_W-1:0] ftq_id;
    } trap_req_t;

    // Vectors held in the CSR file
    typedef struct packed {
        logic [XLEN-1:0] eentry;
        logic [XLEN-1:0] tlbrentry;
        logic [XLEN-1:0] era;
    } csr_vec_t;

    // One lane of the debug commit trace
    typedef struct packed {
        logic [XLEN-1:0]        pc;
        logic [DEBUG_WEN_W-1:0] wen;
        logic [REG_ADDR_W-1:0]  wnum;
        logic [XLEN-1:0]        wdata;
    } trace_t;

endpackage

// ==== src/redirect_arbiter.sv ====
`timescale 1ns/10ps

module redirect_arbiter #(
    parameter int LANES = la_commit_pkg::COMMIT_LANES
) (
    input  la_commit_pkg::trap_req_t                  trap_i,
    input  la_commit_pkg::csr_vec_t                   csr_i,
    input  la_commit_pkg::branch_req_t                branch_i [LANES],
    input  logic                                      ex_stall_i,
    output logic                                      flush_o,
    output logic [la_commit_pkg::XLEN-1:0]            next_pc_o,
    output logic [la_commit_pkg::FTQ_ID_W-1:0]        flush_ftq_id_o
);

    // Trap side of the chain
    logic                               trap_flush;
    logic [la_commit_pkg::XLEN-1:0]     trap_pc;

    // Branch side of the chain
    logic [LANES-1:0]                   branch_valid;
    logic                               branch_flush;
    logic [la_commit_pkg::XLEN-1:0]     branch_pc;
    logic [la_commit_pkg::FTQ_ID_W-1:0] branch_ftq_id;

    // Exception, refill, return and idle in that order
    always_comb begin
        trap_flush = 1'b1;
        if (trap_i.excp && !trap_i.tlbrefill) begin
            trap_pc = csr_i.eentry;
        end else if (trap_i.excp) begin
            trap_pc = csr_i.tlbrentry;
        end else if (trap_i.ertn) begin
            trap_pc = csr_i.era;
        end else if (trap_i.idle) begin
            trap_pc = trap_i.idle_pc;
        end else begin
            trap_flush = 1'b0;
            trap_pc    = '0;
        end
    end

    // A stalled execute stage may hold a flag computed from stale operands
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            branch_valid[i] = branch_i[i].taken && !ex_stall_i;
        end
    end

    // Lowest lane is oldest in program order and wins
    always_comb begin
        branch_flush  = |branch_valid;
        branch_pc     = '0;
        branch_ftq_id = '0;
        for (int i = LANES - 1; i >= 0; i--) begin
            if (branch_valid[i]) begin
                branch_pc     = branch_i[i].target;
                branch_ftq_id = branch_i[i].ftq_id;
            end
        end
    end

    // Merge both halves with traps ahead of branches
    always_comb begin
        flush_o = trap_flush || branch_flush;
        if (trap_flush) begin
            next_pc_o      = trap_pc;
            flush_ftq_id_o = trap_i.ftq_id;
        end else if (branch_flush) begin
            next_pc_o      = branch_pc;
            flush_ftq_id_o = branch_ftq_id;
        end else begin
            next_pc_o      = '0;
            flush_ftq_id_o = '0;
        end
    end

endmodule

// ==== src/arch_regfile.sv ====
`timescale 1ns/10ps

module arch_regfile #(
    parameter int LANES      = la_commit_pkg::COMMIT_LANES,
    parameter int READ_PORTS = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  la_commit_pkg::commit_rec_t            commit_i   [LANES],
    input  logic [la_commit_pkg::REG_ADDR_W-1:0]  rd_addr_i  [READ_PORTS],
    output logic [la_commit_pkg::XLEN-1:0]        rd_data_o  [READ_PORTS]
);

    // General purpose registers
    logic [la_commit_pkg::XLEN-1:0] regs [la_commit_pkg::NUM_REGS];

    // Per lane write qualifier with r0 filtered out
    logic [LANES-1:0] lane_wr;

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            lane_wr[l] = commit_i[l].we && (commit_i[l].waddr != '0);
        end
    end

    // Lanes are applied in order so the youngest write to a register sticks
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int r = 0; r < la_commit_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                if (lane_wr[l]) begin
                    regs[commit_i[l].waddr] <= commit_i[l].wdata;
                end
            end
        end
    end

    // Reads see stored state only with no bypass from this cycle's commits
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            if (rd_addr_i[p] == '0) begin
                rd_data_o[p] = '0;
            end else begin
                rd_data_o[p] = regs[rd_addr_i[p]];
            end
        end
    end

endmodule

// ==== src/commit_trace.sv ====
`timescale 1ns/10ps

module commit_trace #(
    parameter int LANES = la_commit_pkg::COMMIT_LANES
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  la_commit_pkg::commit_rec_t commit_i [LANES],
    output la_commit_pkg::trace_t      trace_o  [LANES]
);

    // Trace word built from the incoming record
    la_commit_pkg::trace_t trace_next [LANES];

    // Lane fields are copied whether or not the lane writes
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            trace_next[l].pc    = commit_i[l].pc;
            trace_next[l].wnum  = commit_i[l].waddr;
            trace_next[l].wdata = commit_i[l].wdata;
            // Single enable bit widened to the debug format
            trace_next[l].wen   = {{(la_commit_pkg::DEBUG_WEN_W - 1){1'b0}}, commit_i[l].we};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int l = 0; l < LANES; l++) begin
                trace_o[l] <= '0;
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                trace_o[l] <= trace_next[l];
            end
        end
    end

endmodule

// ==== src/la_commit_core.sv ====
`timescale 1ns/10ps

module la_commit_core #(
    parameter int LANES      = la_commit_pkg::COMMIT_LANES,
    parameter int READ_PORTS = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,

    // Writeback records from the control unit
    input  la_commit_pkg::commit_rec_t            commit_i   [LANES],

    // Redirect sources
    input  la_commit_pkg::branch_req_t            branch_i   [LANES],
    input  la_commit_pkg::trap_req_t              trap_i,
    input  la_commit_pkg::csr_vec_t               csr_i,
    input  logic                                  ex_stall_i,

    // Register read ports
    input  logic [la_commit_pkg::REG_ADDR_W-1:0]  rd_addr_i  [READ_PORTS],
    output logic [la_commit_pkg::XLEN-1:0]        rd_data_o  [READ_PORTS],

    // Frontend redirect
    output logic                                  flush_o,
    output logic [la_commit_pkg::XLEN-1:0]        next_pc_o,
    output logic [la_commit_pkg::FTQ_ID_W-1:0]    flush_ftq_id_o,

    // Debug commit trace
    output la_commit_pkg::trace_t                 trace_o    [LANES]
);

    // Redirect toward the frontend
    redirect_arbiter #(
        .LANES          (LANES)
    ) u_redirect (
        .trap_i         (trap_i),
        .csr_i          (csr_i),
        .branch_i       (branch_i),
        .ex_stall_i     (ex_stall_i),
        .flush_o        (flush_o),
        .next_pc_o      (next_pc_o),
        .flush_ftq_id_o (flush_ftq_id_o)
    );

    // Architectural state written at commit
    arch_regfile #(
        .LANES      (LANES),
        .READ_PORTS (READ_PORTS)
    ) u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .commit_i   (commit_i),
        .rd_addr_i  (rd_addr_i),
        .rd_data_o  (rd_data_o)
    );

    // Same records seen one cycle later on the trace
    commit_trace #(
        .LANES    (LANES)
    ) u_trace (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .commit_i (commit_i),
        .trace_o  (trace_o)
    );

endmodule

// ==== test/la_commit_core_sva.sv ====
`timescale 1ns/10ps

module la_commit_core_sva #(
    parameter int LANES = la_commit_pkg::COMMIT_LANES
) (
    input logic                               clk,
    input logic                               rst_n_i,
    input la_commit_pkg::commit_rec_t         commit_i [LANES],
    input logic                               flush_o,
    input logic [la_commit_pkg::XLEN-1:0]     next_pc_o,
    input la_commit_pkg::trace_t              trace_o  [LANES]
);

    // Number of failed assertions so far
    int fail_count = 0;

    // An idle frontend redirect carries no target
    a_pc_without_flush: assert property (@(posedge clk) !flush_o |-> next_pc_o == '0)
        else begin
            $error("next_pc_o is nonzero while flush_o is low");
            fail_count++;
        end

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        // Enable bit lands in bit 0 with upper bits clear
        a_wen_follows_we: assert property (@(posedge clk) $past(rst_n_i) |->
            (trace_o[l].wen[0] == $past(commit_i[l].we) &&
             trace_o[l].wen[la_commit_pkg::DEBUG_WEN_W-1:1] == '0))
            else begin
                $error("trace_o[%0d].wen does not follow last cycle's we", l);
                fail_count++;
            end

        // Whole lane cleared by a reset edge
        a_trace_reset: assert property (@(posedge clk) !rst_n_i |=> trace_o[l] == '0)
            else begin
                $error("trace_o[%0d] not cleared after a reset edge", l);
                fail_count++;
            end
    end

endmodule

bind la_commit_core la_commit_core_sva #(
    .LANES     (LANES)
) u_sva (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .commit_i  (commit_i),
    .flush_o   (flush_o),
    .next_pc_o (next_pc_o),
    .trace_o   (trace_o)
);

// ==== test/tb_la_commit_core.sv ====
`timescale 1ns/10ps

module tb_la_commit_core;

    localparam int LANES      = la_commit_pkg::COMMIT_LANES;
    localparam int READ_PORTS = 4;
    localparam int XLEN       = la_commit_pkg::XLEN;
    localparam int AW         = la_commit_pkg::REG_ADDR_W;
    localparam int FTQ_W      = la_commit_pkg::FTQ_ID_W;

    // Expected redirect outcome
    typedef struct packed {
        logic             flush;
        logic [XLEN-1:0]  next_pc;
        logic [FTQ_W-1:0] ftq_id;
    } redirect_t;

    logic                       clk;
    logic                       rst_n;
    la_commit_pkg::commit_rec_t commit  [LANES];
    la_commit_pkg::branch_req_t branch  [LANES];
    la_commit_pkg::trap_req_t   trap;
    la_commit_pkg::csr_vec_t    csr;
    logic                       ex_stall;
    logic [AW-1:0]              rd_addr [READ_PORTS];
    logic [XLEN-1:0]            rd_data [READ_PORTS];
    logic                       flush;
    logic [XLEN-1:0]            next_pc;
    logic [FTQ_W-1:0]           flush_ftq_id;
    la_commit_pkg::trace_t      trace   [LANES];

    // Reference state
    logic [XLEN-1:0]            shadow    [la_commit_pkg::NUM_REGS];
    la_commit_pkg::trace_t      exp_trace [LANES];
    int                         check_cycles = 0;
    integer                     seed = 32'h69da098d;

    la_commit_core u_dut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .commit_i       (commit),
        .branch_i       (branch),
        .trap_i         (trap),
        .csr_i          (csr),
        .ex_stall_i     (ex_stall),
        .rd_addr_i      (rd_addr),
        .rd_data_o      (rd_data),
        .flush_o        (flush),
        .next_pc_o      (next_pc),
        .flush_ftq_id_o (flush_ftq_id),
        .trace_o        (trace)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
    end

    task automatic fail_report(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic la_commit_pkg::commit_rec_t make_commit(
        input logic            we,
        input logic [XLEN-1:0] pc,
        input logic [AW-1:0]   waddr,
        input logic [XLEN-1:0] wdata
    );
        la_commit_pkg::commit_rec_t c;
        c.we    = we;
        c.pc    = pc;
        c.waddr = waddr;
        c.wdata = wdata;
        return c;
    endfunction

    // Exception, refill, return and idle come first and then branches oldest first
    function automatic redirect_t ref_redirect(
        input la_commit_pkg::trap_req_t   t,
        input la_commit_pkg::csr_vec_t    c,
        input la_commit_pkg::branch_req_t b [LANES],
        input logic                       stall
    );
        redirect_t r;
        r = '0;
        if (t.excp || t.ertn || t.idle) begin
            r.flush  = 1'b1;
            r.ftq_id = t.ftq_id;
            if (t.excp) begin
                r.next_pc = t.tlbrefill ? c.tlbrentry : c.eentry;
            end else if (t.ertn) begin
                r.next_pc = c.era;
            end else begin
                r.next_pc = t.idle_pc;
            end
        end else if (!stall) begin
            for (int i = 0; i < LANES; i++) begin
                if (b[i].taken && !r.flush) begin
                    r.flush   = 1'b1;
                    r.next_pc = b[i].target;
                    r.ftq_id  = b[i].ftq_id;
                end
            end
        end
        return r;
    endfunction

    task automatic check_redirect(
        input logic             flush_act,
        input logic [XLEN-1:0]  pc_act,
        input logic [FTQ_W-1:0] id_act,
        input redirect_t        exp
    );
        if (flush_act !== exp.flush) begin
            fail_report($sformatf("[FAIL] t=%0t flush_o got %0b expected %0b",
                $time, flush_act, exp.flush));
        end
        if (pc_act !== exp.next_pc) begin
            fail_report($sformatf("[FAIL] t=%0t next_pc_o got %h expected %h",
                $time, pc_act, exp.next_pc));
        end
        if (id_act !== exp.ftq_id) begin
            fail_report($sformatf("[FAIL] t=%0t flush_ftq_id_o got %0d expected %0d",
                $time, id_act, exp.ftq_id));
        end
    endtask

    task automatic check_reg(
        input int              port,
        input logic [AW-1:0]   addr,
        input logic [XLEN-1:0] act,
        input logic [XLEN-1:0] exp
    );
        if (act !== exp) begin
            fail_report($sformatf("[FAIL] t=%0t rd_data_o[%0d] (r%0d) got %h expected %h",
                $time, port, addr, act, exp));
        end
    endtask

    task automatic check_trace(
        input int                    lane,
        input la_commit_pkg::trace_t act,
        input la_commit_pkg::trace_t exp
    );
        if (act !== exp) begin
            fail_report($sformatf(
                "[FAIL] t=%0t trace_o[%0d] got pc=%h wen=%h wnum=%0d wdata=%h expected %s",
                $time, lane, act.pc, act.wen, act.wnum, act.wdata,
                $sformatf("pc=%h wen=%h wnum=%0d wdata=%h",
                    exp.pc, exp.wen, exp.wnum, exp.wdata)));
        end
    endtask

    // Mirror of what the DUT captures at this edge
    task automatic update_reference();
        if (!rst_n) begin
            for (int r = 0; r < la_commit_pkg::NUM_REGS; r++) begin
                shadow[r] = '0;
            end
            for (int l = 0; l < LANES; l++) begin
                exp_trace[l] = '0;
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                exp_trace[l].pc     = commit[l].pc;
                exp_trace[l].wen    = '0;
                exp_trace[l].wen[0] = commit[l].we;
                exp_trace[l].wnum   = commit[l].waddr;
                exp_trace[l].wdata  = commit[l].wdata;
                // Later lane overwrites and r0 never changes
                if (commit[l].we && commit[l].waddr != '0) begin
                    shadow[commit[l].waddr] = commit[l].wdata;
                end
            end
        end
    endtask

    task automatic clear_inputs();
        for (int l = 0; l < LANES; l++) begin
            commit[l] = '0;
            branch[l] = '0;
        end
        for (int p = 0; p < READ_PORTS; p++) begin
            rd_addr[p] = '0;
        end
        trap     = '0;
        csr      = '0;
        ex_stall = 1'b0;
    endtask

    task automatic randomize_commits();
        logic [31:0] r;
        for (int l = 0; l < LANES; l++) begin
            r = rand32();
            commit[l] = make_commit(r[0], rand32(), r[5:1], rand32());
        end
        // Now and then both lanes hit one register or one lane hits r0
        r = rand32();
        if (r[2:0] == 3'd0) begin
            commit[1].waddr = commit[0].waddr;
        end
        if (r[5:3] == 3'd0) begin
            commit[r[6]].waddr = '0;
        end
    endtask

    task automatic randomize_reads();
        logic [31:0] r;
        for (int p = 0; p < READ_PORTS; p++) begin
            r = rand32();
            rd_addr[p] = r[AW-1:0];
        end
    endtask

    task automatic randomize_redirect();
        logic [31:0] r;
        logic [31:0] b;
        r = rand32();
        trap.excp      = (r[1:0] == 2'd0);
        trap.tlbrefill = r[2];
        trap.ertn      = (r[4:3] == 2'd0);
        trap.idle      = (r[6:5] == 2'd0);
        trap.idle_pc   = rand32();
        trap.ftq_id    = r[9:7];
        ex_stall       = (r[11:10] == 2'd0);
        csr.eentry     = rand32();
        csr.tlbrentry  = rand32();
        csr.era        = rand32();
        for (int l = 0; l < LANES; l++) begin
            b = rand32();
            branch[l].taken  = b[0];
            branch[l].target = rand32();
            branch[l].ftq_id = b[3:1];
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    initial begin : compare
        redirect_t exp_rd;
        forever begin
            @(posedge clk);
            update_reference();
            @(negedge clk);
            for (int l = 0; l < LANES; l++) begin
                check_trace(l, trace[l], exp_trace[l]);
            end
            for (int p = 0; p < READ_PORTS; p++) begin
                check_reg(p, rd_addr[p], rd_data[p], shadow[rd_addr[p]]);
            end
            exp_rd = ref_redirect(trap, csr, branch, ex_stall);
            check_redirect(flush, next_pc, flush_ftq_id, exp_rd);
            if (u_dut.u_sva.fail_count != 0) begin
                fail_report("An assertion in la_commit_core_sva failed");
            end
            check_cycles++;
        end
    end

    initial begin : stimulus
        int        waited;
        int        target;
        redirect_t exp;
        clear_inputs();

        // Writes during reset must not reach the register file
        waited = 0;
        @(posedge clk);
        while (rst_n !== 1'b1) begin
            #2;
            randomize_commits();
            randomize_reads();
            @(posedge clk);
            waited++;
            if (waited > 40) begin
                fail_report("Timeout: reset was never released");
            end
        end
        #2;
        clear_inputs();
        randomize_reads();
        for (int i = 0; i < 4; i++) begin
            step();
            randomize_reads();
        end

        // Both lanes write r7 and then both lanes try r0
        step();
        commit[0] = make_commit(1'b1, 32'h1c00_0000, 5'd7, 32'h1111_aaaa);
        commit[1] = make_commit(1'b1, 32'h1c00_0004, 5'd7, 32'h2222_bbbb);
        step();
        commit[0] = make_commit(1'b1, 32'h1c00_0008, 5'd0, 32'hdead_beef);
        commit[1] = make_commit(1'b1, 32'h1c00_000c, 5'd0, 32'hcafe_f00d);
        rd_addr[0] = 5'd7;
        rd_addr[1] = 5'd0;
        step();
        commit[0] = make_commit(1'b0, 32'h1c00_0010, 5'd3, 32'h0bad_0bad);
        commit[1] = '0;
        #5;
        check_reg(0, 5'd7, rd_data[0], 32'h2222_bbbb);
        check_reg(1, 5'd0, rd_data[1], 32'h0000_0000);

        // Mixed random traffic on every input
        for (int i = 0; i < 400; i++) begin
            step();
            randomize_commits();
            randomize_reads();
            randomize_redirect();
        end

        // Stalled branches alone give nothing while a trap still gets through
        for (int i = 0; i < 16; i++) begin
            step();
            randomize_redirect();
            trap.excp = 1'b0;
            trap.ertn = 1'b0;
            trap.idle = 1'b0;
            ex_stall  = 1'b1;
            for (int l = 0; l < LANES; l++) begin
                branch[l].taken = 1'b1;
            end
            #5;
            check_redirect(flush, next_pc, flush_ftq_id, '0);
            step();
            trap.ertn = 1'b1;
            #5;
            exp.flush   = 1'b1;
            exp.next_pc = csr.era;
            exp.ftq_id  = trap.ftq_id;
            check_redirect(flush, next_pc, flush_ftq_id, exp);
        end

        step();
        clear_inputs();
        target = check_cycles + 3;
        waited = 0;
        while (check_cycles < target) begin
            @(posedge clk);
            waited++;
            if (waited > 20) begin
                fail_report("Timeout: compare process made no progress at end of run");
            end
        end
        if (u_dut.u_sva.fail_count != 0) begin
            $display("Assertion failures reported: %0d", u_dut.u_sva.fail_count);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== la_commit_core.f ====
src/la_commit_pkg.sv
src/redirect_arbiter.sv
src/arch_regfile.sv
src/commit_trace.sv
src/la_commit_core.sv
test/la_commit_core_sva.sv
test/tb_la_commit_core.sv
